// File: tb/bu_stimulus.txt
# name op pc rs1 rs2 imm pred_taken pred_target exp_taken exp_target exp_mis fe_delay
# all hex, op 0..7 = BEQ BNE BLT BGE BLTU BGEU JAL JALR, fe_delay f = flush while held
beq_taken 0 00001000 00000005 00000005 00000010 1 00001010 1 00001010 0 0
bne_not_taken 1 00001100 00000007 00000007 00000020 0 00000000 0 00001104 0 0
blt_signed 2 00002000 ffffffff 00000001 fffffff0 1 00001ff0 1 00001ff0 0 0
bge_signed_min 3 00002100 80000000 7fffffff 00000008 0 00000000 0 00002104 0 0
bltu_max 4 00002200 00000001 ffffffff 00000040 1 00002240 1 00002240 0 0
bgeu_high 5 00002300 80000000 7fffffff 0000000c 1 0000230c 1 0000230c 0 0
jal_fwd 6 00003000 00000000 00000000 00000800 1 00003800 1 00003800 0 0
jalr_bit0 7 00003100 00004001 00000000 00000004 1 00004004 1 00004004 0 0
mis_direction 0 00004000 00000001 00000002 00000010 1 00004010 0 00004004 1 0
mis_target 6 00004100 00000000 00000000 00000020 1 00004200 1 00004120 1 3
mis_not_taken 1 00004200 00000003 00000004 00000008 0 00000000 1 00004208 1 5
mis_flush 7 00004300 00005000 00000000 00000000 1 00000000 1 00005000 1 f
after_flush 2 00004400 00000001 00000002 fffffffc 1 000043fc 1 000043fc 0 0
bgeu_equal 5 00004500 ffffffff ffffffff 00000010 1 00004510 1 00004510 0 0

// File: bu_top.f
design/bu_pkg.sv
design/bu_csr_pkg.sv
design/branch_cu.sv
design/branch_eval.sv
design/bu_perf_regs.sv
design/bu_top.sv
tb/bu_checker.sv
tb/tb_bu_top.sv

// File: tb/tb_bu_top.sv
// --------------------------------------
// Branch unit testbench
// Reads tests from a stimulus file, drives
// issue, frontend, flush and Wishbone
// --------------------------------------

`timescale 1ns/1ps

module tb_bu_top;

  localparam int MAX_TESTS = 32;

  logic clk_i, rst_n_i, flush_i, op_valid_i, pred_taken_i, fe_ready_i;
  logic wb_cyc_i, wb_stb_i, wb_we_i;
  bu_pkg::br_op_t op_i;
  logic [bu_pkg::XLEN-1:0] pc_i, rs1_i, rs2_i, imm_i, pred_target_i, wb_dat_i;
  logic [bu_csr_pkg::WB_AW-1:0] wb_adr_i;
  logic op_ready_o, issue_mis_o, fe_res_valid_o, fe_res_taken_o, fe_res_mis_o, wb_ack_o;
  logic [bu_pkg::XLEN-1:0] fe_res_target_o, wb_dat_o;

  // One row per test from the stimulus file
  string       t_name [MAX_TESTS];
  logic [31:0] t_col [MAX_TESTS][11];
  int          n_tests;
  int          n_accepted;
  int          n_mis;
  bit          loaded;
  logic [31:0] rd_data;

  bu_top i_dut (.*);

  bu_checker i_chk (
    .clk_i(clk_i), .rst_n_i(rst_n_i), .fe_res_valid_i(fe_res_valid_o),
    .fe_res_taken_i(fe_res_taken_o), .fe_res_target_i(fe_res_target_o),
    .fe_res_mis_i(fe_res_mis_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // Skips comment lines starting with #
  task automatic load_tests();
    int    fd;
    int    n;
    string line;
    fd = $fopen("tb/bu_stimulus.txt", "r");
    n_tests = 0;
    if (fd == 0) begin
      $display("Cannot open the stimulus file");
      return;
    end
    while (!$feof(fd) && n_tests < MAX_TESTS) begin
      line = "";
      n = $fgets(line, fd);
      if (n > 1 && line[0] != "#") begin
        n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h", t_name[n_tests],
          t_col[n_tests][0], t_col[n_tests][1], t_col[n_tests][2], t_col[n_tests][3],
          t_col[n_tests][4], t_col[n_tests][5], t_col[n_tests][6], t_col[n_tests][7],
          t_col[n_tests][8], t_col[n_tests][9], t_col[n_tests][10]);
        if (n == 12) n_tests++;
      end
    end
    $fclose(fd);
  endtask

  task automatic wb_access(input logic we, input logic [1:0] adr, input logic [31:0] wdat,
                           output logic [31:0] rdat);
    @(negedge clk_i);
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = we;
    wb_adr_i = adr;
    wb_dat_i = wdat;
    do @(negedge clk_i); while (!wb_ack_o);
    rdat = wb_dat_o;
    // Cycle ends on the edge that samples ack
    @(negedge clk_i);
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
  endtask

  // Flush pulse, then the unit must accept again
  task automatic flush_and_check(input string name);
    flush_i = 1'b1;
    @(negedge clk_i);
    flush_i = 1'b0;
    i_chk.check_word({name, "_valid_after_flush"}, 0, fe_res_valid_o);
    i_chk.check_word({name, "_ready_after_flush"}, 1, op_ready_o);
  endtask

  task automatic run_test(input int i);
    string n;
    int    delay;
    n = t_name[i];
    delay = t_col[i][10];
    i_chk.open_test(n);
    repeat ($urandom % 4) @(negedge clk_i);
    i_chk.expect_res(n, t_col[i][7], t_col[i][8], t_col[i][9]);
    op_valid_i    = 1'b1;
    op_i          = bu_pkg::br_op_t'(t_col[i][0][3:0]);
    pc_i          = t_col[i][1];
    rs1_i         = t_col[i][2];
    rs2_i         = t_col[i][3];
    imm_i         = t_col[i][4];
    pred_taken_i  = t_col[i][5][0];
    pred_target_i = t_col[i][6];
    while (!op_ready_o) @(negedge clk_i);
    @(negedge clk_i);
    op_valid_i = 1'b0;
    n_accepted++;
    i_chk.check_word({n, "_issue_mis"}, t_col[i][9], issue_mis_o);
    if (t_col[i][9][0]) begin
      n_mis++;
      i_chk.check_word({n, "_ready_in_mis"}, 0, op_ready_o);
      @(negedge clk_i);
      // Held resolution while the frontend is busy
      for (int k = 0; k < (delay == 15 ? 2 : delay); k++) begin
        i_chk.check_word({n, "_held_valid"}, 1, fe_res_valid_o);
        @(negedge clk_i);
      end
      if (delay == 15) begin
        flush_and_check(n);
      end else begin
        fe_ready_i = 1'b1;
        @(negedge clk_i);
        fe_ready_i = 1'b0;
        repeat (2) begin
          i_chk.check_word({n, "_stall_valid"}, 0, fe_res_valid_o);
          i_chk.check_word({n, "_stall_ready"}, 0, op_ready_o);
          @(negedge clk_i);
        end
        flush_and_check(n);
      end
    end else begin
      @(negedge clk_i);
    end
    if (i_chk.pending) i_chk.note_failure({"no resolution was offered for ", n});
    i_chk.close_test();
  endtask

  initial begin
    void'($urandom(32'he453_610d));
    {rst_n_i, flush_i, op_valid_i, pred_taken_i, fe_ready_i} = '0;
    {wb_cyc_i, wb_stb_i, wb_we_i, wb_adr_i, wb_dat_i} = '0;
    {pc_i, rs1_i, rs2_i, imm_i, pred_target_i} = '0;
    op_i = bu_pkg::BEQ;
    n_accepted = 0;
    n_mis = 0;
    load_tests();
    loaded = 1'b1;
    repeat (16) @(negedge clk_i);
    rst_n_i = 1'b1;
    @(negedge clk_i);
    i_chk.open_test("reset");
    i_chk.check_word("reset_ready", 1, op_ready_o);
    i_chk.check_word("reset_valid", 0, fe_res_valid_o);
    i_chk.check_word("reset_issue_mis", 0, issue_mis_o);
    i_chk.check_word("reset_ack", 0, wb_ack_o);
    i_chk.close_test();
    for (int i = 0; i < n_tests; i++) run_test(i);
    // Counters against the testbench's own counts
    i_chk.open_test("wb_counts");
    wb_access(1'b0, bu_csr_pkg::REG_BR_CNT, 0, rd_data);
    i_chk.check_word("wb_br_cnt", n_accepted, rd_data);
    wb_access(1'b0, bu_csr_pkg::REG_MIS_CNT, 0, rd_data);
    i_chk.check_word("wb_mis_cnt", n_mis, rd_data);
    i_chk.close_test();
    i_chk.open_test("wb_clear");
    wb_access(1'b1, bu_csr_pkg::REG_CTRL, 32'h1 << bu_csr_pkg::CTRL_CLR_BIT, rd_data);
    wb_access(1'b0, bu_csr_pkg::REG_BR_CNT, 0, rd_data);
    i_chk.check_word("wb_br_cnt_clr", 0, rd_data);
    wb_access(1'b0, bu_csr_pkg::REG_MIS_CNT, 0, rd_data);
    i_chk.check_word("wb_mis_cnt_clr", 0, rd_data);
    i_chk.close_test();
    if (n_tests == 0) i_chk.note_failure("the stimulus file held no tests");
    i_chk.report_totals();
    if (i_chk.errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  // Watchdog allows 64 cycles per test plus reset and bus reads
  initial begin
    wait (loaded);
    repeat (n_tests * 64 + 64) @(posedge clk_i);
    $display("Timeout, the run hung waiting on the DUT");
    $display("Some tests failed");
    $finish;
  end

endmodule

// File: tb/bu_checker.sv
// --------------------------------------
// Branch unit checker
// Compares offered resolutions and other
// values, prints per-test lines and totals
// --------------------------------------

`timescale 1ns/1ps

module bu_checker (
  input logic                    clk_i,
  input logic                    rst_n_i,
  input logic                    fe_res_valid_i,
  input logic                    fe_res_taken_i,
  input logic [bu_pkg::XLEN-1:0] fe_res_target_i,
  input logic                    fe_res_mis_i
);

  string       exp_name;
  logic        exp_taken;
  logic [31:0] exp_target;
  logic        exp_mis;
  bit          pending = 1'b0;
  logic        held_q = 1'b0;
  string       test_name;
  int          test_mark = 0;
  int          errors = 0;
  int          checks = 0;
  int          tests = 0;
  int          failed_tests = 0;

  // Errors from here on count against this test
  task automatic open_test(input string name);
    test_name = name;
    test_mark = errors;
  endtask

  // One line per finished test
  task automatic close_test();
    tests++;
    if (errors == test_mark) begin
      $display("PASS %s", test_name);
    end else begin
      failed_tests++;
      $display("FAIL %s", test_name);
    end
  endtask

  // Armed by the driver before each operation
  task automatic expect_res(input string name, input logic tk, input logic [31:0] tg,
                            input logic mis);
    exp_name   = name;
    exp_taken  = tk;
    exp_target = tg;
    exp_mis    = mis;
    pending    = 1'b1;
  endtask

  task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("[ERROR] %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic note_failure(input string msg);
    errors++;
    $display("FAIL %s", msg);
  endtask

  task automatic report_totals();
    $display("Tests: %0d, failed: %0d, checks: %0d, errors: %0d",
             tests, failed_tests, checks, errors);
  endtask

  // Sampled on the rising edge, before outputs update
  always @(posedge clk_i) begin
    if (rst_n_i && fe_res_valid_i) begin
      if (pending) begin
        pending = 1'b0;
        check_word({exp_name, "_taken"}, exp_taken, fe_res_taken_i);
        check_word({exp_name, "_target"}, exp_target, fe_res_target_i);
        check_word({exp_name, "_mis"}, exp_mis, fe_res_mis_i);
      end else if (!(held_q && fe_res_mis_i)) begin
        note_failure("a resolution was offered with no operation pending");
      end
    end
    held_q <= rst_n_i && fe_res_valid_i && fe_res_mis_i;
  end

endmodule

// File: design/bu_top.sv
// --------------------------------------
// Branch unit top level
// Evaluator, control FSM and the
// statistics register block
// --------------------------------------

`timescale 1ns/1ps

module bu_top (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  input  logic                           flush_i,
  // Issue side
  input  logic                           op_valid_i,
  output logic                           op_ready_o,
  input  bu_pkg::br_op_t                 op_i,
  input  logic [bu_pkg::XLEN-1:0]       pc_i,
  input  logic [bu_pkg::XLEN-1:0]       rs1_i,
  input  logic [bu_pkg::XLEN-1:0]       rs2_i,
  input  logic [bu_pkg::XLEN-1:0]       imm_i,
  input  logic                           pred_taken_i,
  input  logic [bu_pkg::XLEN-1:0]       pred_target_i,
  output logic                           issue_mis_o,
  // Frontend side
  input  logic                           fe_ready_i,
  output logic                           fe_res_valid_o,
  output logic                           fe_res_taken_o,
  output logic [bu_pkg::XLEN-1:0]       fe_res_target_o,
  output logic                           fe_res_mis_o,
  // Wishbone classic
  input  logic                           wb_cyc_i,
  input  logic                           wb_stb_i,
  input  logic                           wb_we_i,
  input  logic [bu_csr_pkg::WB_AW-1:0]  wb_adr_i,
  input  logic [bu_pkg::XLEN-1:0]       wb_dat_i,
  output logic [bu_pkg::XLEN-1:0]       wb_dat_o,
  output logic                           wb_ack_o
);

  // Combinational mispredict into the FSM
  logic mispred;

  // Outcome, target and capture
  branch_eval i_eval (
    .clk_i(clk_i), .rst_n_i(rst_n_i), .op_i(op_i), .pc_i(pc_i),
    .rs1_i(rs1_i), .rs2_i(rs2_i), .imm_i(imm_i),
    .pred_taken_i(pred_taken_i), .pred_target_i(pred_target_i),
    .res_en_i(op_ready_o), .mispred_o(mispred), .res_taken_o(fe_res_taken_o),
    .res_target_o(fe_res_target_o), .res_mis_o(fe_res_mis_o)
  );

  // Capture enable is also issue ready
  branch_cu i_cu (
    .clk_i(clk_i), .rst_n_i(rst_n_i), .flush_i(flush_i), .valid_i(op_valid_i),
    .misprediction_i(mispred), .fe_ready_i(fe_ready_i), .issue_mis_o(issue_mis_o),
    .fe_res_valid_o(fe_res_valid_o), .bu_mis_reg_en_o(op_ready_o)
  );

  // Statistics observe the handshake and the notice
  bu_perf_regs i_perf (
    .clk_i(clk_i), .rst_n_i(rst_n_i), .op_valid_i(op_valid_i),
    .op_ready_i(op_ready_o), .mis_i(issue_mis_o), .wb_cyc_i(wb_cyc_i),
    .wb_stb_i(wb_stb_i), .wb_we_i(wb_we_i), .wb_adr_i(wb_adr_i),
    .wb_dat_i(wb_dat_i), .wb_dat_o(wb_dat_o), .wb_ack_o(wb_ack_o)
  );

endmodule

// File: design/bu_perf_regs.sv
// --------------------------------------
// Branch statistics registers
// Wishbone classic slave counting
// accepted branches and mispredictions
// --------------------------------------

`timescale 1ns/1ps

module bu_perf_regs (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  input  logic                           op_valid_i,
  input  logic                           op_ready_i,
  input  logic                           mis_i,
  input  logic                           wb_cyc_i,
  input  logic                           wb_stb_i,
  input  logic                           wb_we_i,
  input  logic [bu_csr_pkg::WB_AW-1:0]  wb_adr_i,
  input  logic [bu_pkg::XLEN-1:0]       wb_dat_i,
  output logic [bu_pkg::XLEN-1:0]       wb_dat_o,
  output logic                           wb_ack_o
);

  logic [bu_pkg::XLEN-1:0] br_cnt_q;
  logic [bu_pkg::XLEN-1:0] mis_cnt_q;
  logic                    wb_req;
  logic                    clr;

  // New request, not yet acknowledged
  assign wb_req = wb_cyc_i && wb_stb_i && !wb_ack_o;

  // Clear command on the control register
  assign clr = wb_req && wb_we_i && (wb_adr_i == bu_csr_pkg::REG_CTRL) &&
               wb_dat_i[bu_csr_pkg::CTRL_CLR_BIT];

  // --------------------------------------
  // Counters
  // --------------------------------------

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      br_cnt_q  <= '0;
      mis_cnt_q <= '0;
    end else if (clr) begin
      br_cnt_q  <= '0;
      mis_cnt_q <= '0;
    end else begin
      // Handshake on the issue side
      if (op_valid_i && op_ready_i) br_cnt_q <= br_cnt_q + 1'b1;
      if (mis_i) mis_cnt_q <= mis_cnt_q + 1'b1;
    end
  end

  // --------------------------------------
  // Bus side
  // --------------------------------------

  // Single cycle ack after the request
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) wb_ack_o <= 1'b0;
    else wb_ack_o <= wb_req;
  end

  // Read data valid with ack
  always_ff @(posedge clk_i) begin
    if (wb_req) begin
      case (wb_adr_i)
        bu_csr_pkg::REG_BR_CNT:  wb_dat_o <= br_cnt_q;
        bu_csr_pkg::REG_MIS_CNT: wb_dat_o <= mis_cnt_q;
        default:                 wb_dat_o <= '0;
      endcase
    end
  end

  // Ack only inside a cycle the master still holds
  a_ack_req : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    wb_ack_o |-> wb_cyc_i && wb_stb_i);

endmodule

// File: design/branch_eval.sv
// --------------------------------------
// Branch evaluator
// Computes outcome and target, detects
// mispredictions and holds the resolution
// --------------------------------------

`timescale 1ns/1ps

module branch_eval (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  bu_pkg::br_op_t           op_i,
  input  logic [bu_pkg::XLEN-1:0] pc_i,
  input  logic [bu_pkg::XLEN-1:0] rs1_i,
  input  logic [bu_pkg::XLEN-1:0] rs2_i,
  input  logic [bu_pkg::XLEN-1:0] imm_i,
  input  logic                     pred_taken_i,
  input  logic [bu_pkg::XLEN-1:0] pred_target_i,
  input  logic                     res_en_i,
  output logic                     mispred_o,
  output logic                     res_taken_o,
  output logic [bu_pkg::XLEN-1:0] res_target_o,
  output logic                     res_mis_o
);

  logic                     taken;
  logic [bu_pkg::XLEN-1:0] target;
  logic [bu_pkg::XLEN-1:0] pc_rel;
  logic [bu_pkg::XLEN-1:0] pc_next;
  logic [bu_pkg::XLEN-1:0] jalr_sum;

  // --------------------------------------
  // Outcome
  // --------------------------------------

  always_comb begin
    case (op_i)
      bu_pkg::BEQ:  taken = (rs1_i == rs2_i);
      bu_pkg::BNE:  taken = (rs1_i != rs2_i);
      bu_pkg::BLT:  taken = ($signed(rs1_i) < $signed(rs2_i));
      bu_pkg::BGE:  taken = ($signed(rs1_i) >= $signed(rs2_i));
      bu_pkg::BLTU: taken = (rs1_i < rs2_i);
      bu_pkg::BGEU: taken = (rs1_i >= rs2_i);
      // Jumps are always taken
      bu_pkg::JAL, bu_pkg::JALR: taken = 1'b1;
      default: taken = 1'b0;
    endcase
  end

  // --------------------------------------
  // Target
  // --------------------------------------

  assign pc_rel   = pc_i + imm_i;
  assign pc_next  = pc_i + bu_pkg::XLEN'(bu_pkg::INSTR_BYTES);
  assign jalr_sum = rs1_i + imm_i;

  // JALR clears the lowest bit of the sum
  always_comb begin
    if (op_i == bu_pkg::JALR) begin
      target = {jalr_sum[bu_pkg::XLEN-1:1], 1'b0};
    end else if (taken) begin
      target = pc_rel;
    end else begin
      target = pc_next;
    end
  end

  // Wrong direction, or taken to the wrong place
  assign mispred_o = (taken != pred_taken_i) || (taken && (target != pred_target_i));

  // --------------------------------------
  // Resolution register
  // --------------------------------------

  // Outcome and mispredict flag
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      res_taken_o <= 1'b0;
      res_mis_o   <= 1'b0;
    end else if (res_en_i) begin
      res_taken_o <= taken;
      res_mis_o   <= mispred_o;
    end
  end

  // Target address
  always_ff @(posedge clk_i) begin
    if (res_en_i) begin
      res_target_o <= target;
    end
  end

endmodule

// File: design/branch_cu.sv
// --------------------------------------
// Branch unit control FSM
// Sequences resolution capture, the
// misprediction notice, frontend handoff
// and the stall until flush
// --------------------------------------

`timescale 1ns/1ps

module branch_cu (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic flush_i,
  input  logic valid_i,
  input  logic misprediction_i,
  input  logic fe_ready_i,
  output logic issue_mis_o,
  output logic fe_res_valid_o,
  output logic bu_mis_reg_en_o
);

  // FSM states
  typedef enum logic [2:0] {
    IDLE,
    UPD_FE,
    MIS,
    MIS_LOAD_PC,
    STALL
  } cu_state_t;

  cu_state_t state_q, state_d;

  // --------------------------------------
  // Next state
  // --------------------------------------

  always_comb begin
    state_d = state_q;
    case (state_q)
      // Open for a new branch
      IDLE, UPD_FE: begin
        if (valid_i && misprediction_i) begin
          state_d = MIS;
        end else if (valid_i) begin
          state_d = UPD_FE;
        end else begin
          state_d = IDLE;
        end
      end
      // One cycle notice to issue
      MIS: state_d = MIS_LOAD_PC;
      // Hold resolution for the frontend
      MIS_LOAD_PC: begin
        if (fe_ready_i) begin
          state_d = STALL;
        end
      end
      // Only flush leaves this state
      STALL: state_d = STALL;
      default: state_d = IDLE;
    endcase
  end

  // --------------------------------------
  // Moore outputs
  // --------------------------------------

  // Capture enable doubles as issue ready
  assign bu_mis_reg_en_o = (state_q == IDLE) || (state_q == UPD_FE);
  assign fe_res_valid_o  = (state_q == UPD_FE) || (state_q == MIS_LOAD_PC);
  assign issue_mis_o     = (state_q == MIS);

  // State register with synchronous flush
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
    end else if (flush_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Held resolution is released right after the handoff
  a_mis_handoff : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (state_q == MIS_LOAD_PC) && fe_ready_i |=> !fe_res_valid_o);

  // No resolution offered while stalled and not flushed
  a_stall_quiet : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (state_q == STALL) && !flush_i |=> !fe_res_valid_o && !bu_mis_reg_en_o);

endmodule

// File: design/bu_csr_pkg.sv
// --------------------------------------
// Statistics register map
// Wishbone offsets and control bits
// --------------------------------------

package bu_csr_pkg;

  // Wishbone word-address width
  localparam int unsigned WB_AW = 2;

  // Word addresses
  // Accepted branch counter
  localparam logic [WB_AW-1:0] REG_BR_CNT = 2'd0;
  // Misprediction counter
  localparam logic [WB_AW-1:0] REG_MIS_CNT = 2'd1;
  // Write-only control register
  localparam logic [WB_AW-1:0] REG_CTRL = 2'd2;

  // Control register bits
  // Writing one clears both counters
  localparam int unsigned CTRL_CLR_BIT = 0;

endpackage

// File: design/bu_pkg.sv
// --------------------------------------
// Branch unit package
// Operation encodings and datapath sizes
// shared by the branch unit blocks
// --------------------------------------

package bu_pkg;

  // --------------------------------------
  // Datapath sizes
  // --------------------------------------

  // Data and address width
  localparam int unsigned XLEN = 32;

  // Width of the operation code
  localparam int unsigned BR_OP_W = 4;

  // Size of one instruction in bytes
  // Fall-through target is pc plus this
  localparam int unsigned INSTR_BYTES = 4;

  // --------------------------------------
  // Branch operation encodings
  // --------------------------------------

  typedef enum logic [BR_OP_W-1:0] {
    BEQ  = 4'h0,
    BNE  = 4'h1,
    BLT  = 4'h2,
    BGE  = 4'h3,
    BLTU = 4'h4,
    BGEU = 4'h5,
    JAL  = 4'h6,
    JALR = 4'h7
  } br_op_t;

endpackage
